// ==== dv/gb_cart_props.sv ====
`timescale 1ns/1ps

module gb_cart_props (
	input logic                  clk_sys,
	input logic                  reset,
	input gb_cart_pkg::mapper_t   mapper,
	input gb_cart_pkg::rom_bank_t rom_bank,
	input logic                  ram_enable
);
	import gb_cart_pkg::*;

	int fail_cnt = 0; // summed into the run total by the testbench

	// ----------------------------------------
	// bank register rules
	// ----------------------------------------
	reset_state: assert property (@(posedge clk_sys)
		reset |=> (!ram_enable && rom_bank == rom_bank_t'(1)))
		else begin
			$error("bank registers not at their reset values after reset");
			fail_cnt++;
		end

	// only mbc5 can select bank 0 in the switched window
	no_bank_zero: assert property (@(posedge clk_sys) disable iff (reset)
		(mapper != MAP_MBC5) |-> (rom_bank[6:0] != 7'd0))
		else begin
			$error("rom bank 0 selected on a mapper other than mbc5");
			fail_cnt++;
		end

endmodule

// ==== dv/gb_cart_tb.sv ====
`timescale 1ns/1ps
`include "gb_cart_params.svh"

module gb_cart_tb;
	import gb_cart_pkg::*;

	localparam int RST = 11, HDR = 6;           // cycles per reset and per header load
	localparam int N_RD1 = 40, N_OPS2 = 8, N_MBC5 = 20, N_OPS4 = 80;
	localparam int TEST_CYCLES = RST + N_RD1 * 2 + 60 * (RST + HDR + N_OPS2 * 4)
		+ RST + HDR + N_MBC5 * 6 + 4 * (RST + HDR + 4 + N_OPS4 * 4);
	localparam int LIMIT = TEST_CYCLES * 3 / 2;

	logic clk_sys, reset, cpu_ce, cpu_rd, cpu_wr, dl_active, dl_wr;
	logic [15:0] cpu_addr, dl_data, rom_data;
	logic [7:0]  cpu_wdata, cpu_rdata;
	logic [24:0] dl_addr;
	logic [23:0] rom_addr;
	logic        rom_rd;

	// reference model state
	mapper_t     m_mapper;
	logic [8:0]  m_rom_mask, m_rom_bank;
	logic [3:0]  m_ram_mask, m_ram_bank;
	logic        m_ram_en, m_mode1, m_mode3;
	logic [7:0]  mmem [0:131071];
	bit          mvalid [0:131071]; // written at least once
	logic [7:0]  codes [6] = '{8'h00, 8'h02, 8'h06, 8'h11, 8'h1b, 8'h20};
	logic [7:0]  ram_maps [4] = '{8'h03, 8'h06, 8'h10, 8'h1e};
	integer      seed = 32'hd82c8559;
	logic [31:0] r;
	int          errors = 0, checks = 0, cycles = 0;

	gb_cart dut (.*);

	bind mbc_regs gb_cart_props u_props (.clk_sys(clk_sys), .reset(reset), .mapper(mapper),
		.rom_bank(rom_bank), .ram_enable(ram_enable));

	// rom contents depend on every address bit
	function automatic logic [15:0] rom_word(input logic [23:0] a);
		return {a[7:0] ^ a[23:16], a[15:8] ^ 8'h3c};
	endfunction

	assign rom_data = rom_word(rom_addr); // external rom with no latency

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("checks: %0d  errors: %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ----------------------------------------
	// model
	// ----------------------------------------
	function automatic mapper_t decode_mapper(input logic [7:0] c);
		if (c >= 8'd1 && c <= 8'd3)
			return MAP_MBC1;
		if (c == 8'd5 || c == 8'd6)
			return MAP_MBC2;
		if (c >= 8'd15 && c <= 8'd19)
			return MAP_MBC3; // rtc variants too
		if (c >= 8'd25 && c <= 8'd30)
			return MAP_MBC5;
		return MAP_NONE;
	endfunction

	function automatic logic [23:0] exp_rom_addr(input logic [15:0] a);
		logic [8:0] b;
		logic [9:0] f;
		case (m_mapper)
			MAP_MBC1: b = {2'b00, {(m_mode1 ? 2'b00 : m_ram_bank[1:0]), m_rom_bank[4:0]}
				& m_rom_mask[6:0]};
			MAP_MBC5: b = m_rom_bank & m_rom_mask;
			default:  b = {2'b00, m_rom_bank[6:0] & m_rom_mask[6:0]};
		endcase
		if (m_mapper == MAP_NONE)
			f = {8'd0, a[14:13]};
		else if (a < 16'h4000)
			f = {9'd0, a[13]}; // fixed window
		else if (a < 16'h8000)
			f = {b, a[13]};
		else
			f = 10'd0;
		return {2'b00, f, a[12:1]};
	endfunction

	function automatic logic [16:0] ram_addr(input logic [15:0] a);
		logic [3:0] b;
		case (m_mapper)
			MAP_MBC1:           b = m_mode1 ? (m_ram_bank & m_ram_mask) : 4'd0;
			MAP_MBC3, MAP_MBC5: b = m_ram_bank & m_ram_mask;
			default:            b = 4'd0;
		endcase
		return {b, a[12:0]};
	endfunction

	task automatic check_equal(input string what, input logic [23:0] got, input logic [23:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------
	// bus drivers
	// ----------------------------------------
	task automatic apply_reset();
		@(posedge clk_sys);
		reset  <= 1'b1;
		cpu_rd <= 1'b0;
		cpu_wr <= 1'b0;
		repeat (10) @(posedge clk_sys);
		reset      <= 1'b0;
		m_mapper   = MAP_NONE;
		m_rom_mask = 9'd1; // size code 0
		m_ram_mask = 4'd0;
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		{m_ram_en, m_mode1, m_mode3} = 3'b000;
	endtask

	task automatic dl_write(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		{dl_active, dl_wr} <= 2'b11;
		dl_addr <= a;
		dl_data <= d;
		@(posedge clk_sys); // taken here
		{dl_active, dl_wr} <= 2'b00;
	endtask

	task automatic load_header(input logic [7:0] code, input logic [7:0] rom_sz,
		input logic [7:0] ram_sz);
		r = $random(seed);
		dl_write(`HDR_CGB_ADDR, r[15:0]); // not decoded
		dl_write(`HDR_TYPE_ADDR, {code, r[23:16]});
		dl_write(`HDR_SIZE_ADDR, {ram_sz, rom_sz});
		m_mapper = decode_mapper(code);
		if (rom_sz == 8'd0)
			m_rom_mask = 9'd1;
		else if (rom_sz <= 8'd8)
			m_rom_mask = 9'h1ff >> (8'd8 - rom_sz); // size 8 keeps all nine bits
		else
			m_rom_mask = 9'h07f;
		m_ram_mask = (ram_sz <= 8'd2) ? 4'h0 : (ram_sz == 8'd3) ? 4'h3 : 4'hf;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr  <= a;
		cpu_wdata <= d;
		cpu_wr    <= 1'b1;
		@(posedge clk_sys);
		cpu_wr <= 1'b0;
		case (a[15:13])
			3'd0: m_ram_en = (d[3:0] == 4'ha);
			3'd1: begin
				if (m_mapper == MAP_MBC5 && a[12])
					m_rom_bank[8] = d[0];
				else if (m_mapper == MAP_MBC5)
					m_rom_bank[7:0] = d;
				else
					m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
			end
			3'd2: begin
				if (m_mapper == MAP_MBC3 && d[3])
					m_mode3 = 1'b1;
				else if (m_mapper == MAP_MBC5)
					m_ram_bank = d[3:0];
				else begin
					m_mode3    = 1'b0; // only mbc3 uses it
					m_ram_bank = {2'b00, d[1:0]};
				end
			end
			3'd3: if (m_mapper == MAP_MBC1) m_mode1 = d[0];
			3'd5: begin
				mmem[ram_addr(a)]   = d; // enable does not gate writes
				mvalid[ram_addr(a)] = 1'b1;
			end
			default: ;
		endcase
	endtask

	// write strobe with cpu_ce low, nothing in the cart may change
	task automatic write_ce_low(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_ce    <= 1'b0;
		cpu_addr  <= a;
		cpu_wdata <= d;
		cpu_wr    <= 1'b1;
		@(posedge clk_sys);
		cpu_ce <= 1'b1;
		cpu_wr <= 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] a);
		logic [23:0] ea;
		logic [15:0] w;
		logic [16:0] ra;
		logic [7:0]  ed;
		logic        known;
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_rd   <= 1'b1;
		@(negedge clk_sys);
		ea = exp_rom_addr(a);
		ra = ram_addr(a);
		w  = rom_word(ea);
		check_equal("rom_addr", rom_addr, ea);
		check_equal("rom_rd", rom_rd, a[15:13] != 3'b101);
		@(posedge clk_sys); // read data captured here
		cpu_rd <= 1'b0;
		@(negedge clk_sys);
		check_equal("rom_rd idle", rom_rd, 1'b0); // cpu_rd is low again
		known = 1'b1;
		if (a[15:13] != 3'b101)
			ed = a[0] ? w[15:8] : w[7:0];
		else if (!m_ram_en)
			ed = 8'hff;
		else if (m_mapper == MAP_MBC2 && a[15:9] == 7'h50) begin
			ed    = {4'hf, mmem[ra][3:0]};
			known = mvalid[ra];
		end else if (m_mapper == MAP_MBC3 && m_mode3)
			ed = 8'h00;
		else begin
			ed    = mmem[ra];
			known = mvalid[ra];
		end
		if (known)
			check_equal("cpu_rdata", cpu_rdata, ed);
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	initial begin
		reset <= 1'b1;
		cpu_ce <= 1'b1;
		{cpu_rd, cpu_wr, dl_active, dl_wr} <= 4'b0000;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		dl_addr <= '0;
		dl_data <= '0;

		apply_reset(); // plain rom with linear addresses
		repeat (N_RD1) begin
			r = $random(seed);
			cpu_read(r[15:0]);
		end

		foreach (codes[i]) begin // every mapper and rom size
			for (int s = 0; s < 10; s++) begin
				apply_reset();
				r = $random(seed);
				load_header(codes[i], 8'(s), {5'd0, r[2:0]});
				for (int k = 0; k < N_OPS2; k++) begin
					r = $random(seed);
					if (k == 0)
						cpu_write(16'h2000, 8'h00); // written as bank 1
					else
						cpu_write({1'b0, r[14:0]}, r[23:16]);
					cpu_read({1'b0, r[31:17]});
				end
			end
		end

		apply_reset(); // mbc5 with 8 MB
		load_header(8'h19, 8'd8, 8'd0);
		repeat (N_MBC5) begin
			r = $random(seed);
			cpu_write(16'h3000 | r[11:0], r[23:16]); // bank bit 8
			cpu_write(16'h2000 | r[11:0], r[31:24]);
			cpu_read(16'h4000 | r[29:16]);
		end

		foreach (ram_maps[i]) begin // banked ram, enable, mbc2 nibbles, mbc3 rtc
			apply_reset();
			load_header(ram_maps[i], 8'd2, 8'd4);
			cpu_write(16'h6000, 8'h01); // mbc1 ram banking mode
			cpu_write(16'h0000, 8'h0a);
			for (int k = 0; k < N_OPS4; k++) begin
				r = $random(seed);
				case (r[2:0])
					3'd0: cpu_write({3'b000, r[12:0]}, r[3] ? 8'h0a : r[15:8]);
					3'd1: cpu_write({3'b010, r[12:0]}, r[15:8]);
					3'd2, 3'd3: begin
						cpu_write(16'ha000 | (r[31:16] & 16'h0207), r[15:8]);
						cpu_read(16'ha000 | (r[31:16] & 16'h0207));
					end
					3'd4: begin
						write_ce_low(r[3] ? 16'h0000 : (16'ha000 | (r[31:16] & 16'h0207)),
							r[15:8]);
						cpu_read(16'ha000 | (r[31:16] & 16'h0207));
					end
					default: cpu_read(16'ha000 | (r[31:16] & 16'h0207));
				endcase
			end
		end

		errors = errors + dut.u_regs.u_props.fail_cnt;
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== gb_cart.f ====
+incdir+hw
hw/gb_cart_pkg.sv
hw/cart_bank_if.sv
hw/cart_header.sv
hw/mbc_regs.sv
hw/rom_map.sv
hw/cart_ram.sv
hw/gb_cart.sv
dv/gb_cart_props.sv
dv/gb_cart_tb.sv

// ==== hw/cart_bank_if.sv ====
`timescale 1ns/1ps

interface cart_bank_if;
	import gb_cart_pkg::*;

	// header side
	mapper_t   mapper;
	rom_mask_t rom_mask;
	ram_mask_t ram_mask;

	// cpu written registers
	rom_bank_t rom_bank;
	ram_bank_t ram_bank;
	logic      ram_enable;
	logic      mbc1_mode; // 0 selects 16/8 mode
	logic      mbc3_mode; // 1 selects rtc at a000

	modport hdr (output mapper, rom_mask, ram_mask);
	modport ctrl (input mapper,
		output rom_bank, ram_bank, ram_enable, mbc1_mode, mbc3_mode);
	modport map (input mapper, rom_mask, ram_mask, rom_bank, ram_bank,
		ram_enable, mbc1_mode, mbc3_mode);
	modport ram (input mapper, rom_mask, ram_mask, rom_bank, ram_bank,
		ram_enable, mbc1_mode, mbc3_mode);

endinterface

// ==== hw/cart_header.sv ====
`timescale 1ns/1ps
`include "gb_cart_params.svh"

module cart_header (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [`DL_DATA_W-1:0] dl_data,
	cart_bank_if.hdr              bank
);
	import gb_cart_pkg::*;

	logic [7:0] type_code; // raw mapper byte
	logic [7:0] rom_code;  // raw rom size byte
	logic [7:0] ram_code;  // raw ram size byte
	logic [9:0] mask_full; // one bit wider than the rom mask
	logic       dl_we;
	cart_hdr_t  hdr;

	assign dl_we = dl_active & dl_wr;

	// ----------------------------------------
	// header byte capture
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_code <= 8'h00;
			rom_code  <= 8'h00;
			ram_code  <= 8'h00;
		end else if (dl_we) begin
			case (dl_addr)
				`HDR_TYPE_ADDR: type_code <= dl_data[15:8];
				`HDR_SIZE_ADDR: {ram_code, rom_code} <= dl_data; // both sizes in one word
				default: ;
			endcase
		end
	end

	// 2^(size+1)-1 banks
	assign mask_full = (10'd1 << (rom_code[3:0] + 4'd1)) - 10'd1;

	always_comb begin
		case (type_code) inside
			[8'd1:8'd3]:   hdr.mapper = MAP_MBC1;
			[8'd5:8'd6]:   hdr.mapper = MAP_MBC2;
			[8'd15:8'd19]: hdr.mapper = MAP_MBC3; // with and without rtc
			[8'd25:8'd30]: hdr.mapper = MAP_MBC5;
			default:       hdr.mapper = MAP_NONE; // unknown mappers run as plain rom
		endcase

		if (rom_code == 8'd0)
			hdr.rom_mask = rom_mask_t'(1); // 32k, two banks
		else if (rom_code <= 8'd8)
			hdr.rom_mask = mask_full[`ROM_BANK_W-1:0];
		else
			hdr.rom_mask = rom_mask_t'(7'h7f); // odd 1.1M to 1.5M sizes

		if (ram_code <= 8'd2)
			hdr.ram_mask = '0;          // none, 2k or 8k in one bank
		else if (ram_code == 8'd3)
			hdr.ram_mask = 4'h3;        // 32k in 4 banks
		else
			hdr.ram_mask = 4'hf;        // 128k in 16 banks
	end

	assign bank.mapper   = hdr.mapper;
	assign bank.rom_mask = hdr.rom_mask;
	assign bank.ram_mask = hdr.ram_mask;

endmodule

// ==== hw/cart_ram.sv ====
`timescale 1ns/1ps
`include "gb_cart_params.svh"

module cart_ram (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cpu_ce,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic [`CART_DATA_W-1:0] cpu_wdata,
	input  logic [`DL_DATA_W-1:0]   rom_data,
	cart_bank_if.ram                bank,
	output logic [`CART_DATA_W-1:0] cpu_rdata
);
	import gb_cart_pkg::*;

	logic [`CART_DATA_W-1:0] mem [0:(1 << `CRAM_ADDR_W)-1]; // 16 banks of 8k
	logic                    in_cram;
	ram_bank_t               ram_sel;
	logic [`CRAM_ADDR_W-1:0] cram_addr;
	logic [`CART_DATA_W-1:0] cram_q;
	logic [`CART_DATA_W-1:0] cram_byte; // after enable and mapper rules
	logic [`CART_DATA_W-1:0] rom_byte;

	assign in_cram = (cpu_addr[15:13] == `REG_CRAM);

	// ----------------------------------------
	// ram banking
	// ----------------------------------------
	always_comb begin
		case (bank.mapper)
			MAP_MBC1:           ram_sel = bank.mbc1_mode ? (bank.ram_bank & bank.ram_mask) : '0;
			MAP_MBC3, MAP_MBC5: ram_sel = bank.ram_bank & bank.ram_mask;
			default:            ram_sel = '0; // mbc2 and plain carts have one bank
		endcase
	end

	assign cram_addr = {ram_sel, cpu_addr[12:0]};

	// the enable does not guard writes
	always_ff @(posedge clk_sys) begin
		if (cpu_ce & cpu_wr & in_cram)
			mem[cram_addr] <= cpu_wdata;
	end

	assign cram_q = mem[cram_addr];

	// ----------------------------------------
	// read byte selection
	// ----------------------------------------
	always_comb begin
		if (!bank.ram_enable)
			cram_byte = 8'hff; // locked ram floats high
		else if (bank.mapper == MAP_MBC2 && cpu_addr[15:9] == 7'b1010000)
			cram_byte = {4'hf, cram_q[3:0]}; // 512 x 4 bit ram
		else if (bank.mapper == MAP_MBC3 && bank.mbc3_mode)
			cram_byte = 8'h00; // no rtc behind it
		else
			cram_byte = cram_q;
	end

	assign rom_byte = cpu_addr[0] ? rom_data[15:8] : rom_data[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset)
			cpu_rdata <= '0;
		else if (cpu_rd)
			cpu_rdata <= in_cram ? cram_byte : rom_byte; // valid one cycle after cpu_rd
	end

endmodule

// ==== hw/gb_cart.sv ====
`timescale 1ns/1ps
`include "gb_cart_params.svh"

module gb_cart (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cpu_ce,
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic                    cpu_rd,
	input  logic                    cpu_wr,
	input  logic [`CART_DATA_W-1:0] cpu_wdata,
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [`DL_DATA_W-1:0]   dl_data,
	input  logic [`DL_DATA_W-1:0]   rom_data,  // rom word at rom_addr
	output logic [`ROM_WADDR_W-1:0] rom_addr,
	output logic                    rom_rd,
	output logic [`CART_DATA_W-1:0] cpu_rdata
);

	cart_bank_if bank ();

	// header decode during rom download
	cart_header u_header (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.bank      (bank.hdr)
	);

	mbc_regs u_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.bank      (bank.ctrl)
	);

	rom_map u_rom_map (
		.cpu_addr (cpu_addr),
		.cpu_rd   (cpu_rd),
		.bank     (bank.map),
		.rom_addr (rom_addr),
		.rom_rd   (rom_rd)
	);

	// cart ram and the read data mux
	cart_ram u_ram (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.cpu_rd    (cpu_rd),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.rom_data  (rom_data),
		.bank      (bank.ram),
		.cpu_rdata (cpu_rdata)
	);

endmodule

// ==== hw/gb_cart_params.svh ====
`ifndef GB_CART_PARAMS_SVH
`define GB_CART_PARAMS_SVH

// bus widths
`define CART_ADDR_W    16  // cpu address
`define CART_DATA_W    8   // cpu data
`define ROM_WADDR_W    24  // rom word address
`define DL_ADDR_W      25  // download byte address
`define DL_DATA_W      16  // download word
`define ROM_BANK_W     9   // up to 512 rom banks
`define RAM_BANK_W     4   // up to 16 ram banks
`define CRAM_ADDR_W    17  // 128 KB of cart ram

// cartridge header locations in the download stream
`define HDR_CGB_ADDR   25'h142  // colour flag, not decoded here
`define HDR_TYPE_ADDR  25'h146  // mapper code in the high byte
`define HDR_SIZE_ADDR  25'h148  // rom size low byte and ram size high byte

// cpu address regions, taken from cpu_addr[15:13]
`define REG_RAM_EN     3'b000  // 0000-1fff
`define REG_ROM_BANK   3'b001  // 2000-3fff
`define REG_RAM_BANK   3'b010  // 4000-5fff
`define REG_MODE       3'b011  // 6000-7fff
`define REG_CRAM       3'b101  // a000-bfff

`define RAM_ENABLE_KEY 4'ha    // low nibble that unlocks the ram

`endif

// ==== hw/gb_cart_pkg.sv ====
`include "gb_cart_params.svh"

package gb_cart_pkg;

	// ----------------------------------------
	// mapper kinds
	// ----------------------------------------
	typedef enum logic [2:0] {
		MAP_NONE, // plain 32k rom
		MAP_MBC1,
		MAP_MBC2,
		MAP_MBC3,
		MAP_MBC5
	} mapper_t;

	// masks used for rom and ram mirroring
	typedef logic [`ROM_BANK_W-1:0] rom_mask_t;
	typedef logic [`RAM_BANK_W-1:0] ram_mask_t;

	// bank registers as written by the cpu
	typedef logic [`ROM_BANK_W-1:0] rom_bank_t;
	typedef logic [`RAM_BANK_W-1:0] ram_bank_t;

	// decoded header, one word
	typedef struct packed {
		mapper_t   mapper;
		rom_mask_t rom_mask;
		ram_mask_t ram_mask;
	} cart_hdr_t;

endpackage

// ==== hw/mbc_regs.sv ====
`timescale 1ns/1ps
`include "gb_cart_params.svh"

module mbc_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cpu_ce,
	input  logic                    cpu_wr,
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic [`CART_DATA_W-1:0] cpu_wdata,
	cart_bank_if.ctrl               bank
);
	import gb_cart_pkg::*;

	rom_bank_t  rom_bank;
	ram_bank_t  ram_bank;
	logic       ram_enable;
	logic       mbc1_mode;
	logic       mbc3_mode;
	mapper_t    mapper;
	logic       cpu_we;    // accepted cpu write
	logic [2:0] region;    // 8k slice of the cpu map

	assign mapper = bank.mapper;
	assign cpu_we = cpu_ce & cpu_wr;
	assign region = cpu_addr[15:13];

	// ----------------------------------------
	// register writes into the rom area
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= rom_bank_t'(1); // bank 1 sits at 4000 after power up
			ram_bank   <= '0;
			ram_enable <= 1'b0;
			mbc1_mode  <= 1'b0;
			mbc3_mode  <= 1'b0;
		end else if (cpu_we) begin
			case (region)
				`REG_RAM_EN: ram_enable <= (cpu_wdata[3:0] == `RAM_ENABLE_KEY);

				`REG_ROM_BANK: begin
					if (mapper == MAP_MBC5) begin
						// mbc5 splits the 9 bit bank over two registers
						if (cpu_addr[12])
							rom_bank[8] <= cpu_wdata[0];    // 3000-3fff
						else
							rom_bank[7:0] <= cpu_wdata;     // 2000-2fff
					end else if (cpu_wdata[6:0] == 7'd0) begin
						rom_bank <= rom_bank_t'(1);         // bank 0 maps to 1
					end else begin
						rom_bank <= {2'b00, cpu_wdata[6:0]};
					end
				end

				`REG_RAM_BANK: begin
					if (mapper == MAP_MBC3) begin
						if (cpu_wdata[3]) begin
							mbc3_mode <= 1'b1;               // rtc register selected
						end else begin
							mbc3_mode <= 1'b0;               // back to ram
							ram_bank  <= {2'b00, cpu_wdata[1:0]};
						end
					end else if (mapper == MAP_MBC5) begin
						ram_bank <= cpu_wdata[3:0];          // all 16 banks
					end else begin
						ram_bank <= {2'b00, cpu_wdata[1:0]};
					end
				end

				`REG_MODE: begin
					if (mapper == MAP_MBC1)
						mbc1_mode <= cpu_wdata[0]; // only mbc1 has a mode select
				end

				default: ;
			endcase
		end
	end

	assign bank.rom_bank   = rom_bank;
	assign bank.ram_bank   = ram_bank;
	assign bank.ram_enable = ram_enable;
	assign bank.mbc1_mode  = mbc1_mode;
	assign bank.mbc3_mode  = mbc3_mode;

endmodule

// ==== hw/rom_map.sv ====
`timescale 1ns/1ps
`include "gb_cart_params.svh"

module rom_map (
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic                    cpu_rd,
	cart_bank_if.map                bank,
	output logic [`ROM_WADDR_W-1:0] rom_addr,
	output logic                    rom_rd
);
	import gb_cart_pkg::*;

	logic [6:0] mbc1_bank;  // ram bank bits on top in mode 0
	rom_bank_t  eff_bank;   // masked bank for mirroring
	logic [9:0] bank_field; // 16k bank plus the 8k half

	always_comb begin
		mbc1_bank = {bank.mbc1_mode ? 2'b00 : bank.ram_bank[1:0], bank.rom_bank[4:0]};

		case (bank.mapper)
			MAP_MBC1: eff_bank = {2'b00, mbc1_bank & bank.rom_mask[6:0]};
			MAP_MBC5: eff_bank = bank.rom_bank & bank.rom_mask; // full 9 bits
			default:  eff_bank = {2'b00, bank.rom_bank[6:0] & bank.rom_mask[6:0]};
		endcase

		if (bank.mapper == MAP_NONE) begin
			bank_field = {8'd0, cpu_addr[14:13]}; // linear 32k
		end else begin
			case (cpu_addr[15:14])
				2'b00:   bank_field = {9'd0, cpu_addr[13]};    // fixed bank 0
				2'b01:   bank_field = {eff_bank, cpu_addr[13]}; // switched bank
				default: bank_field = 10'd0;
			endcase
		end
	end

	// word address, byte lane picked later from cpu_addr[0]
	assign rom_addr = {2'b00, bank_field, cpu_addr[12:1]};
	assign rom_rd   = cpu_rd & (cpu_addr[15:13] != `REG_CRAM);

endmodule
